//--- source/decode_latch.sv
`timescale 1ns/1ns

module decode_latch (
    input  logic                clk,
    input  logic                rstn,
    input  logic                in_valid,
    input  logic                flush,
    input  logic                out_ready,
    input  logic                load_stall,
    input  isa_pkg::inst_word_u in_inst,
    input  pipe_pkg::word_t     in_pc,
    output logic                in_ready,
    output logic                stage_valid,
    output isa_pkg::inst_word_u inst,
    output pipe_pkg::word_t     pc
);

    logic ready_go;

    assign ready_go = stage_valid & ~load_stall;
    assign in_ready = ~stage_valid | (ready_go & out_ready);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;
        end else if (in_ready) begin
            // bubble when nothing is offered
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            inst <= in_inst;
            pc   <= in_pc;
        end
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk,
    input  logic                rstn,
    input  logic                in_valid,
    input  logic                flush,
    input  logic                out_ready,
    input  logic                e_is_load,
    input  logic                wb_we,
    input  isa_pkg::inst_word_u in_inst,
    input  pipe_pkg::word_t     in_pc,
    input  pipe_pkg::word_t     e_wdata,
    input  pipe_pkg::word_t     m_wdata,
    input  pipe_pkg::word_t     wb_data,
    input  isa_pkg::reg_idx_t   e_dest,
    input  isa_pkg::reg_idx_t   m_dest,
    input  isa_pkg::reg_idx_t   wb_addr,
    output logic                in_ready,
    output logic                out_valid,
    output pipe_pkg::word_t     out_pc,
    output pipe_pkg::alu_op_t   alu_op,
    output pipe_pkg::word_t     alu_src1,
    output pipe_pkg::word_t     alu_src2,
    output pipe_pkg::word_t     store_data,
    output logic                gr_we,
    output pipe_pkg::lane_t     mem_we,
    output pipe_pkg::lane_t     load_mode,
    output isa_pkg::reg_idx_t   dest,
    output logic                illegal
);

    isa_pkg::inst_word_u inst;
    logic                stage_valid;
    logic                load_stall;

    operand_sel_if sel_if ();

    decode_latch u_latch (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .flush      (flush),
        .out_ready  (out_ready),
        .load_stall (load_stall),
        .in_inst    (in_inst),
        .in_pc      (in_pc),
        .in_ready   (in_ready),
        .stage_valid(stage_valid),
        .inst       (inst),
        .pc         (out_pc)
    );

    inst_decoder u_dec (
        .inst     (inst),
        .sel      (sel_if.dec),
        .alu_op   (alu_op),
        .gr_we    (gr_we),
        .mem_we   (mem_we),
        .load_mode(load_mode),
        .dest     (dest),
        .illegal  (illegal)
    );

    operand_read u_opr (
        .clk       (clk),
        .sel       (sel_if.rd),
        .pc        (out_pc),
        .e_dest    (e_dest),
        .m_dest    (m_dest),
        .wb_addr   (wb_addr),
        .e_wdata   (e_wdata),
        .m_wdata   (m_wdata),
        .wb_data   (wb_data),
        .e_is_load (e_is_load),
        .wb_we     (wb_we),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .store_data(store_data),
        .load_stall(load_stall)
    );

    assign out_valid = stage_valid & ~load_stall;

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  isa_pkg::inst_word_u inst,
    operand_sel_if.dec          sel,
    output pipe_pkg::alu_op_t   alu_op,
    output logic                gr_we,
    output pipe_pkg::lane_t     mem_we,
    output pipe_pkg::lane_t     load_mode,
    output isa_pkg::reg_idx_t   dest,
    output logic                illegal
);

    logic i_add, i_sub, i_slt, i_sltu, i_nor, i_and, i_or, i_xor;
    logic i_sll, i_srl, i_sra, i_slli, i_srli, i_srai;
    logic i_slti, i_sltui, i_addi, i_andi, i_ori, i_xori;
    logic i_lu12i, i_pcadd;
    logic i_ld_b, i_ld_h, i_ld_w, i_ld_bu, i_ld_hu, i_st_b, i_st_h, i_st_w;
    logic is_load, is_store, need_ui12, need_i20;

    // 3R view
    assign i_add  = inst.r3.opcode == isa_pkg::op3r_add;
    assign i_sub  = inst.r3.opcode == isa_pkg::op3r_sub;
    assign i_slt  = inst.r3.opcode == isa_pkg::op3r_slt;
    assign i_sltu = inst.r3.opcode == isa_pkg::op3r_sltu;
    assign i_nor  = inst.r3.opcode == isa_pkg::op3r_nor;
    assign i_and  = inst.r3.opcode == isa_pkg::op3r_and;
    assign i_or   = inst.r3.opcode == isa_pkg::op3r_or;
    assign i_xor  = inst.r3.opcode == isa_pkg::op3r_xor;
    assign i_sll  = inst.r3.opcode == isa_pkg::op3r_sll;
    assign i_srl  = inst.r3.opcode == isa_pkg::op3r_srl;
    assign i_sra  = inst.r3.opcode == isa_pkg::op3r_sra;
    assign i_slli = inst.r3.opcode == isa_pkg::op3r_slli;
    assign i_srli = inst.r3.opcode == isa_pkg::op3r_srli;
    assign i_srai = inst.r3.opcode == isa_pkg::op3r_srai;

    // 2RI12 view
    assign i_slti  = inst.ri12.opcode == isa_pkg::op12_slti;
    assign i_sltui = inst.ri12.opcode == isa_pkg::op12_sltui;
    assign i_addi  = inst.ri12.opcode == isa_pkg::op12_addi;
    assign i_andi  = inst.ri12.opcode == isa_pkg::op12_andi;
    assign i_ori   = inst.ri12.opcode == isa_pkg::op12_ori;
    assign i_xori  = inst.ri12.opcode == isa_pkg::op12_xori;
    assign i_ld_b  = inst.ri12.opcode == isa_pkg::op12_ld_b;
    assign i_ld_h  = inst.ri12.opcode == isa_pkg::op12_ld_h;
    assign i_ld_w  = inst.ri12.opcode == isa_pkg::op12_ld_w;
    assign i_ld_bu = inst.ri12.opcode == isa_pkg::op12_ld_bu;
    assign i_ld_hu = inst.ri12.opcode == isa_pkg::op12_ld_hu;
    assign i_st_b  = inst.ri12.opcode == isa_pkg::op12_st_b;
    assign i_st_h  = inst.ri12.opcode == isa_pkg::op12_st_h;
    assign i_st_w  = inst.ri12.opcode == isa_pkg::op12_st_w;

    // 1RI20 view
    assign i_lu12i = inst.ri20.opcode == isa_pkg::op20_lu12i;
    assign i_pcadd = inst.ri20.opcode == isa_pkg::op20_pcaddu12i;

    assign is_load   = i_ld_b | i_ld_h | i_ld_w | i_ld_bu | i_ld_hu;
    assign is_store  = i_st_b | i_st_h | i_st_w;
    assign need_ui12 = i_andi | i_ori | i_xori;
    assign need_i20  = i_lu12i | i_pcadd;

    always_comb begin
        alu_op = '0;
        alu_op[pipe_pkg::alu_add]  = i_add | i_addi | is_load | is_store | i_pcadd;
        alu_op[pipe_pkg::alu_sub]  = i_sub;
        alu_op[pipe_pkg::alu_slt]  = i_slt | i_slti;
        alu_op[pipe_pkg::alu_sltu] = i_sltu | i_sltui;
        alu_op[pipe_pkg::alu_and]  = i_and | i_andi;
        alu_op[pipe_pkg::alu_nor]  = i_nor;
        alu_op[pipe_pkg::alu_or]   = i_or | i_ori;
        alu_op[pipe_pkg::alu_xor]  = i_xor | i_xori;
        alu_op[pipe_pkg::alu_sll]  = i_sll | i_slli;
        alu_op[pipe_pkg::alu_srl]  = i_srl | i_srli;
        alu_op[pipe_pkg::alu_sra]  = i_sra | i_srai;
        alu_op[pipe_pkg::alu_lui]  = i_lu12i;
    end

    // ui5 of the shift forms sits in the low bits of the si12 path
    always_comb begin
        if (need_i20) begin
            sel.imm = {inst.ri20.imm, 12'b0};
        end else if (need_ui12) begin
            sel.imm = {20'b0, inst.ri12.imm};
        end else begin
            sel.imm = {{20{inst.ri12.imm[11]}}, inst.ri12.imm};
        end
    end

    assign sel.src1_idx    = inst.r3.rj;
    assign sel.src2_idx    = is_store ? inst.r3.rd : inst.r3.rk;
    assign sel.src1_is_pc  = i_pcadd;
    assign sel.src2_is_imm = i_slli | i_srli | i_srai | i_slti | i_sltui | i_addi |
                             need_ui12 | need_i20 | is_load | is_store;

    assign illegal = ~|{i_add, i_sub, i_slt, i_sltu, i_nor, i_and, i_or, i_xor,
                        i_sll, i_srl, i_sra, i_slli, i_srli, i_srai,
                        i_slti, i_sltui, i_addi, i_andi, i_ori, i_xori,
                        need_i20, is_load, is_store};

    assign gr_we = ~is_store & ~illegal;
    assign dest  = inst.r3.rd;

    assign mem_we = i_st_w ? pipe_pkg::st_w :
                    i_st_h ? pipe_pkg::st_h :
                    i_st_b ? pipe_pkg::st_b : 4'b0000;

    assign load_mode = i_ld_w  ? pipe_pkg::ld_w  :
                       i_ld_b  ? pipe_pkg::ld_b  :
                       i_ld_bu ? pipe_pkg::ld_bu :
                       i_ld_h  ? pipe_pkg::ld_h  :
                       i_ld_hu ? pipe_pkg::ld_hu : pipe_pkg::ld_none;

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    // register-register form, also used by the shift-immediate forms
    typedef struct packed {
        logic [16:0] opcode;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm;
        reg_idx_t    rd;
    } fmt_1ri20_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_1ri20_t ri20;
    } inst_word_u;

    // inst[31:15]
    localparam logic [16:0] op3r_add  = 17'h00020;
    localparam logic [16:0] op3r_sub  = 17'h00022;
    localparam logic [16:0] op3r_slt  = 17'h00024;
    localparam logic [16:0] op3r_sltu = 17'h00025;
    localparam logic [16:0] op3r_nor  = 17'h00028;
    localparam logic [16:0] op3r_and  = 17'h00029;
    localparam logic [16:0] op3r_or   = 17'h0002a;
    localparam logic [16:0] op3r_xor  = 17'h0002b;
    localparam logic [16:0] op3r_sll  = 17'h0002e;
    localparam logic [16:0] op3r_srl  = 17'h0002f;
    localparam logic [16:0] op3r_sra  = 17'h00030;
    localparam logic [16:0] op3r_slli = 17'h00081;
    localparam logic [16:0] op3r_srli = 17'h00089;
    localparam logic [16:0] op3r_srai = 17'h00091;

    // inst[31:22]
    localparam logic [9:0] op12_slti  = 10'h008;
    localparam logic [9:0] op12_sltui = 10'h009;
    localparam logic [9:0] op12_addi  = 10'h00a;
    localparam logic [9:0] op12_andi  = 10'h00d;
    localparam logic [9:0] op12_ori   = 10'h00e;
    localparam logic [9:0] op12_xori  = 10'h00f;
    localparam logic [9:0] op12_ld_b  = 10'h0a0;
    localparam logic [9:0] op12_ld_h  = 10'h0a1;
    localparam logic [9:0] op12_ld_w  = 10'h0a2;
    localparam logic [9:0] op12_st_b  = 10'h0a4;
    localparam logic [9:0] op12_st_h  = 10'h0a5;
    localparam logic [9:0] op12_st_w  = 10'h0a6;
    localparam logic [9:0] op12_ld_bu = 10'h0a8;
    localparam logic [9:0] op12_ld_hu = 10'h0a9;

    // inst[31:25]
    localparam logic [6:0] op20_lu12i     = 7'h0a;
    localparam logic [6:0] op20_pcaddu12i = 7'h0e;

endpackage

//--- source/operand_read.sv
`timescale 1ns/1ns

module operand_read (
    input  logic              clk,
    operand_sel_if.rd         sel,
    input  pipe_pkg::word_t   pc,
    input  isa_pkg::reg_idx_t e_dest,
    input  isa_pkg::reg_idx_t m_dest,
    input  isa_pkg::reg_idx_t wb_addr,
    input  pipe_pkg::word_t   e_wdata,
    input  pipe_pkg::word_t   m_wdata,
    input  pipe_pkg::word_t   wb_data,
    input  logic              e_is_load,
    input  logic              wb_we,
    output pipe_pkg::word_t   alu_src1,
    output pipe_pkg::word_t   alu_src2,
    output pipe_pkg::word_t   store_data,
    output logic              load_stall
);

    pipe_pkg::word_t rf [32];
    pipe_pkg::word_t src1_val;
    pipe_pkg::word_t src2_val;
    logic            hit1_e;
    logic            hit2_e;

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wb_we && wb_addr != 5'd0) begin
            rf[wb_addr] <= wb_data;
        end
    end

    // priority E, M, W, then the array
    function automatic pipe_pkg::word_t bypass(input isa_pkg::reg_idx_t idx);
        pipe_pkg::word_t val;
        if (idx == 5'd0) begin
            val = '0;
        end else if (idx == e_dest) begin
            val = e_wdata;
        end else if (idx == m_dest) begin
            val = m_wdata;
        end else if (wb_we && idx == wb_addr) begin
            val = wb_data;
        end else begin
            val = rf[idx];
        end
        return val;
    endfunction

    always_comb begin
        src1_val = bypass(sel.src1_idx);
        src2_val = bypass(sel.src2_idx);
    end

    assign hit1_e = sel.src1_idx != 5'd0 && sel.src1_idx == e_dest;
    assign hit2_e = sel.src2_idx != 5'd0 && sel.src2_idx == e_dest;

    // load data is not ready until M
    assign load_stall = e_is_load & (hit1_e | hit2_e);

    assign alu_src1   = sel.src1_is_pc ? pc : src1_val;
    assign alu_src2   = sel.src2_is_imm ? sel.imm : src2_val;
    assign store_data = src2_val;

endmodule

//--- source/operand_sel_if.sv
`timescale 1ns/1ns

interface operand_sel_if;

    isa_pkg::reg_idx_t src1_idx;
    isa_pkg::reg_idx_t src2_idx;
    logic              src1_is_pc;
    logic              src2_is_imm;
    // already extended
    pipe_pkg::word_t   imm;

    modport dec (
        output src1_idx, src2_idx, src1_is_pc, src2_is_imm, imm
    );

    modport rd (
        input src1_idx, src2_idx, src1_is_pc, src2_is_imm, imm
    );

endinterface

//--- source/pipe_pkg.sv
package pipe_pkg;

    localparam int alu_w = 12;

    typedef logic [alu_w-1:0] alu_op_t;
    typedef logic [3:0]       lane_t;
    typedef logic [31:0]      word_t;

    // one-hot alu_op bit positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // load mode, bit 2 marks zero extension
    localparam lane_t ld_none = 4'b0000;
    localparam lane_t ld_w    = 4'b1111;
    localparam lane_t ld_b    = 4'b0001;
    localparam lane_t ld_bu   = 4'b0101;
    localparam lane_t ld_h    = 4'b0011;
    localparam lane_t ld_hu   = 4'b0111;

    // store byte enables before alignment
    localparam lane_t st_w = 4'b1111;
    localparam lane_t st_h = 4'b0011;
    localparam lane_t st_b = 4'b0001;

endpackage

//--- testbench/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage;

    typedef struct packed {
        isa_pkg::reg_idx_t e_dest;
        isa_pkg::reg_idx_t m_dest;
        isa_pkg::reg_idx_t wb_addr;
        pipe_pkg::word_t   e_wdata;
        pipe_pkg::word_t   m_wdata;
        pipe_pkg::word_t   wb_data;
        logic              e_is_load;
        logic              wb_we;
    } byp_t;

    typedef struct packed {
        pipe_pkg::alu_op_t alu_op;
        pipe_pkg::word_t   src1;
        pipe_pkg::word_t   src2;
        pipe_pkg::word_t   sdata;
        logic              gr_we;
        pipe_pkg::lane_t   mem_we;
        pipe_pkg::lane_t   load_mode;
        isa_pkg::reg_idx_t dest;
        logic              illegal;
        logic              stall;
    } exp_t;

    localparam int n_basic = 40;
    localparam int n_mix   = 300;
    localparam int n_total = 31 + 30 + n_basic + 12 + n_mix;

    // the last three 3R entries are the shift-immediate forms
    localparam logic [16:0] op3r_tab [14] = '{
        isa_pkg::op3r_add, isa_pkg::op3r_sub, isa_pkg::op3r_slt, isa_pkg::op3r_sltu,
        isa_pkg::op3r_nor, isa_pkg::op3r_and, isa_pkg::op3r_or, isa_pkg::op3r_xor,
        isa_pkg::op3r_sll, isa_pkg::op3r_srl, isa_pkg::op3r_sra,
        isa_pkg::op3r_slli, isa_pkg::op3r_srli, isa_pkg::op3r_srai};
    localparam int alu3r_tab [14] = '{
        pipe_pkg::alu_add, pipe_pkg::alu_sub, pipe_pkg::alu_slt, pipe_pkg::alu_sltu,
        pipe_pkg::alu_nor, pipe_pkg::alu_and, pipe_pkg::alu_or, pipe_pkg::alu_xor,
        pipe_pkg::alu_sll, pipe_pkg::alu_srl, pipe_pkg::alu_sra,
        pipe_pkg::alu_sll, pipe_pkg::alu_srl, pipe_pkg::alu_sra};
    localparam logic [9:0] op12_tab [14] = '{
        isa_pkg::op12_slti, isa_pkg::op12_sltui, isa_pkg::op12_addi, isa_pkg::op12_andi,
        isa_pkg::op12_ori, isa_pkg::op12_xori, isa_pkg::op12_ld_b, isa_pkg::op12_ld_h,
        isa_pkg::op12_ld_w, isa_pkg::op12_ld_bu, isa_pkg::op12_ld_hu,
        isa_pkg::op12_st_b, isa_pkg::op12_st_h, isa_pkg::op12_st_w};
    localparam int alu12_tab [14] = '{
        pipe_pkg::alu_slt, pipe_pkg::alu_sltu, pipe_pkg::alu_add, pipe_pkg::alu_and,
        pipe_pkg::alu_or, pipe_pkg::alu_xor, pipe_pkg::alu_add, pipe_pkg::alu_add,
        pipe_pkg::alu_add, pipe_pkg::alu_add, pipe_pkg::alu_add,
        pipe_pkg::alu_add, pipe_pkg::alu_add, pipe_pkg::alu_add};
    localparam logic [6:0] op20_tab [2] = '{isa_pkg::op20_lu12i, isa_pkg::op20_pcaddu12i};
    localparam int alu20_tab [2] = '{pipe_pkg::alu_lui, pipe_pkg::alu_add};

    logic              clk;
    logic              rstn;
    logic              in_valid;
    logic              flush;
    logic              out_ready;
    logic [31:0]       in_inst;
    pipe_pkg::word_t   in_pc;
    byp_t              byp;
    logic              in_ready;
    logic              out_valid;
    pipe_pkg::word_t   out_pc;
    pipe_pkg::alu_op_t alu_op;
    pipe_pkg::word_t   alu_src1;
    pipe_pkg::word_t   alu_src2;
    pipe_pkg::word_t   store_data;
    logic              gr_we;
    pipe_pkg::lane_t   mem_we;
    pipe_pkg::lane_t   load_mode;
    isa_pkg::reg_idx_t dest;
    logic              illegal;

    pipe_pkg::word_t shadow [32];
    logic [31:0]     lfsr;
    pipe_pkg::word_t pc_next;
    int              errors = 0;
    int              checks = 0;
    // model of the stage register
    logic            held_valid;
    logic [31:0]     held_inst;
    pipe_pkg::word_t held_pc;
    exp_t            cur;
    logic            exp_ov;
    logic            exp_ir;

    decode_stage dut (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .flush     (flush),
        .out_ready (out_ready),
        .e_is_load (byp.e_is_load),
        .wb_we     (byp.wb_we),
        .in_inst   (in_inst),
        .in_pc     (in_pc),
        .e_wdata   (byp.e_wdata),
        .m_wdata   (byp.m_wdata),
        .wb_data   (byp.wb_data),
        .e_dest    (byp.e_dest),
        .m_dest    (byp.m_dest),
        .wb_addr   (byp.wb_addr),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .alu_op    (alu_op),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .store_data(store_data),
        .gr_we     (gr_we),
        .mem_we    (mem_we),
        .load_mode (load_mode),
        .dest      (dest),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // k 0..29 picks a kept opcode, 30 gives a raw random word
    function automatic logic [31:0] make_inst(input int k, input logic [31:0] f);
        logic [31:0] w;
        if (k < 14) begin
            w = {op3r_tab[k], f[14:0]};
        end else if (k < 28) begin
            w = {op12_tab[k-14], f[21:0]};
        end else if (k < 30) begin
            w = {op20_tab[k-28], f[24:0]};
        end else begin
            w = f;
        end
        return w;
    endfunction

    function automatic pipe_pkg::word_t reg_value(input isa_pkg::reg_idx_t idx,
                                                  input pipe_pkg::word_t regs [32],
                                                  input byp_t b);
        pipe_pkg::word_t v;
        if (idx == 5'd0) begin
            v = '0;
        end else if (b.e_dest == idx) begin
            v = b.e_wdata;
        end else if (b.m_dest == idx) begin
            v = b.m_wdata;
        end else if (b.wb_we && b.wb_addr == idx) begin
            v = b.wb_data;
        end else begin
            v = regs[idx];
        end
        return v;
    endfunction

    function automatic exp_t decode_ref(input logic [31:0] w, input pipe_pkg::word_t pc,
                                        input pipe_pkg::word_t regs [32], input byp_t b);
        exp_t              r;
        int                k;
        logic              use_imm;
        logic              is_st;
        isa_pkg::reg_idx_t s2;
        pipe_pkg::word_t   imm;
        pipe_pkg::word_t   v2;
        r = '0;
        k = -1;
        use_imm = 1'b1;
        for (int i = 0; i < 14; i++) begin
            if (w[31:15] == op3r_tab[i]) begin
                k = alu3r_tab[i];
                use_imm = (i >= 11);
            end
            if (w[31:22] == op12_tab[i]) begin
                k = alu12_tab[i];
            end
        end
        for (int i = 0; i < 2; i++) begin
            if (w[31:25] == op20_tab[i]) begin
                k = alu20_tab[i];
            end
        end
        is_st = w[31:22] inside {isa_pkg::op12_st_b, isa_pkg::op12_st_h, isa_pkg::op12_st_w};
        if (w[31:25] inside {isa_pkg::op20_lu12i, isa_pkg::op20_pcaddu12i}) begin
            imm = {w[24:5], 12'b0};
        end else if (w[31:22] inside {isa_pkg::op12_andi, isa_pkg::op12_ori,
                                      isa_pkg::op12_xori}) begin
            imm = {20'b0, w[21:10]};
        end else begin
            imm = {{20{w[21]}}, w[21:10]};
        end
        s2 = is_st ? w[4:0] : w[14:10];
        v2 = reg_value(s2, regs, b);
        r.illegal = (k < 0);
        if (k >= 0) begin
            r.alu_op[k] = 1'b1;
        end
        r.src1 = (w[31:25] == isa_pkg::op20_pcaddu12i) ? pc : reg_value(w[9:5], regs, b);
        r.src2 = (use_imm && !r.illegal) ? imm : v2;
        r.sdata = v2;
        r.gr_we = !is_st && !r.illegal;
        r.dest = w[4:0];
        case (w[31:22])
            isa_pkg::op12_st_w:  r.mem_we = pipe_pkg::st_w;
            isa_pkg::op12_st_h:  r.mem_we = pipe_pkg::st_h;
            isa_pkg::op12_st_b:  r.mem_we = pipe_pkg::st_b;
            isa_pkg::op12_ld_w:  r.load_mode = pipe_pkg::ld_w;
            isa_pkg::op12_ld_h:  r.load_mode = pipe_pkg::ld_h;
            isa_pkg::op12_ld_hu: r.load_mode = pipe_pkg::ld_hu;
            isa_pkg::op12_ld_b:  r.load_mode = pipe_pkg::ld_b;
            isa_pkg::op12_ld_bu: r.load_mode = pipe_pkg::ld_bu;
            default: ;
        endcase
        r.stall = b.e_is_load && b.e_dest != 5'd0 && (b.e_dest == w[9:5] || b.e_dest == s2);
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge clk) begin
        if (byp.wb_we && byp.wb_addr != 5'd0) begin
            shadow[byp.wb_addr] <= byp.wb_data;
        end
    end

    always @(posedge clk) begin
        if (!rstn) begin
            held_valid = 1'b0;
        end else begin
            cur = decode_ref(held_inst, held_pc, shadow, byp);
            exp_ov = held_valid && !cur.stall;
            exp_ir = !held_valid || (exp_ov && out_ready);
            check_field("out_valid", exp_ov, out_valid);
            check_field("in_ready", exp_ir, in_ready);
            if (exp_ov) begin
                check_field("out_pc", held_pc, out_pc);
            end
            if (out_valid && out_ready) begin
                checks++;
                check_field("alu_op", cur.alu_op, alu_op);
                check_field("alu_src1", cur.src1, alu_src1);
                check_field("alu_src2", cur.src2, alu_src2);
                check_field("store_data", cur.sdata, store_data);
                check_field("gr_we", cur.gr_we, gr_we);
                check_field("mem_we", cur.mem_we, mem_we);
                check_field("load_mode", cur.load_mode, load_mode);
                check_field("dest", cur.dest, dest);
                check_field("illegal", cur.illegal, illegal);
            end
            if (flush) begin
                held_valid = 1'b0;
            end else if (exp_ir) begin
                held_valid = in_valid;
                if (in_valid) begin
                    held_inst = in_inst;
                    held_pc = in_pc;
                end
            end
        end
    end

    // offer one instruction, wait for acceptance and one more cycle
    task automatic issue(input logic [31:0] w);
        @(negedge clk);
        in_valid = 1'b1;
        in_inst = w;
        in_pc = pc_next;
        pc_next = pc_next + 32'd4;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    initial begin
        rstn = 1'b0;
        in_valid = 1'b0;
        flush = 1'b0;
        out_ready = 1'b1;
        in_inst = '0;
        in_pc = '0;
        byp = '0;
        lfsr = 32'hfaec5685;
        pc_next = 32'h1c000000;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        for (int r = 1; r < 32; r++) begin
            byp.wb_we = 1'b1;
            byp.wb_addr = r[4:0];
            byp.wb_data = rand_bits(32);
            @(negedge clk);
        end
        byp = '0;
        // every kept opcode once, then random ones
        for (int k = 0; k < 30; k++) begin
            issue(make_inst(k, rand_bits(32)));
        end
        repeat (n_basic) issue(make_inst(rand_bits(5) % 30, rand_bits(32)));
        issue({isa_pkg::op3r_add, 5'd0, 5'd0, 5'd2});
        // same register on E, M and W, then drop them one by one
        byp = '{5'd7, 5'd7, 5'd7, rand_bits(32), rand_bits(32), rand_bits(32), 1'b0, 1'b1};
        issue({isa_pkg::op3r_or, 5'd7, 5'd7, 5'd3});
        byp.e_dest = 5'd0;
        issue({isa_pkg::op3r_or, 5'd7, 5'd7, 5'd3});
        byp.m_dest = 5'd0;
        // W gets fresh data only once the store sits in the stage
        byp.wb_we = 1'b0;
        fork
            issue({isa_pkg::op12_st_w, 12'h010, 5'd7, 5'd7});
            begin
                @(negedge clk);
                @(posedge clk);
                while (!in_ready) begin
                    @(posedge clk);
                end
                @(negedge clk);
                byp.wb_we = 1'b1;
                byp.wb_data = rand_bits(32);
            end
        join
        byp.wb_we = 1'b0;
        issue({isa_pkg::op3r_or, 5'd7, 5'd7, 5'd3});
        // load-use stall
        byp = '{5'd9, 5'd0, 5'd0, rand_bits(32), 32'h0, 32'h0, 1'b1, 1'b0};
        issue({isa_pkg::op3r_sub, 5'd4, 5'd9, 5'd5});
        repeat (3) @(negedge clk);
        byp.e_is_load = 1'b0;
        repeat (2) @(negedge clk);
        // back-pressure, then a flushed instruction
        out_ready = 1'b0;
        issue({isa_pkg::op12_addi, 12'hfff, 5'd6, 5'd8});
        repeat (3) @(negedge clk);
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
        issue({isa_pkg::op12_ld_hu, 12'h123, 5'd10, 5'd11});
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        out_ready = 1'b1;
        repeat (2) @(negedge clk);
        issue(32'hffffffff);
        issue(32'h00000000);
        repeat (n_mix) begin
            in_valid = rand_bits(1);
            in_inst = make_inst(rand_bits(5) % 31, rand_bits(32));
            in_pc = rand_bits(30) << 2;
            out_ready = rand_bits(2) != 2'd0;
            flush = rand_bits(4) == 4'd0;
            byp.e_dest = rand_bits(5);
            byp.m_dest = rand_bits(5);
            byp.wb_addr = rand_bits(5);
            byp.e_wdata = rand_bits(32);
            byp.m_wdata = rand_bits(32);
            byp.wb_data = rand_bits(32);
            byp.e_is_load = rand_bits(2) == 2'd0;
            byp.wb_we = rand_bits(1);
            @(negedge clk);
        end
        in_valid = 1'b0;
        flush = 1'b0;
        out_ready = 1'b1;
        byp = '0;
        repeat (3) @(negedge clk);
        $display("%0d handshakes checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #((8 + 40 * n_total) * 8);
        $display("Timeout: the run did not finish in time, %0d errors so far", errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- vlog.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/operand_sel_if.sv
source/decode_latch.sv
source/inst_decoder.sv
source/operand_read.sv
source/decode_stage.sv
testbench/tb_decode_stage.sv
